// ==== include/elink_params.svh ====
/*
 * elink transmit parameters
 * word, tick and transaction limits shared by design and testbench
 */
`ifndef ELINK_PARAMS_SVH
`define ELINK_PARAMS_SVH

// ####################
// widths
// ####################
`define ELINK_TICK_W   4                   // heartbeat every 2**n cycles
`define ELINK_WORD_W   32                  // transmit word
`define ELINK_BYTES    (`ELINK_WORD_W / 8) // bytes per word on the wire
`define ELINK_LEN_W    4                   // header length field

// ####################
// transaction limits
// ####################
`define ELINK_MAX_LEN  15                  // data words after one control word

`endif

// ==== verilog/elink_pkg.sv ====
/*
 * elink shared types
 * reset sequencer states, opcodes and the two views of a link word
 */
`include "elink_params.svh"

package elink_pkg;

   // reset sequence, steps only on heartbeat
   typedef enum logic [2:0] {
      reset_all  = 3'd0,
      start_pll  = 3'd1,
      stop_pll   = 3'd2,
      start_chip = 3'd3,
      hold       = 3'd4,
      active     = 3'd5
   } reset_state_t;

   // known opcodes, anything else is reserved
   typedef enum logic [3:0] {
      write         = 4'h1,
      read          = 4'h2,
      read_response = 4'h3
   } link_opcode_t;

   // control header layout, opcode in the top nibble
   typedef struct packed {
      link_opcode_t                                opcode;
      logic [`ELINK_LEN_W-1:0]                     len;    // data words that follow
      logic [`ELINK_WORD_W-`ELINK_LEN_W-5:0]       addr;
   } link_hdr_t;

   // one word, header view or plain data
   typedef union packed {
      logic [`ELINK_WORD_W-1:0] raw;
      link_hdr_t                hdr;
   } link_word_u;

endpackage

// ==== verilog/elink_reset_seq.sv ====
/*
 * elink reset sequencer
 * walks pll reset, chip reset and link reset through the bring-up order,
 * one step per heartbeat, waiting on pll lock where needed
 */
`include "elink_params.svh"

module elink_reset_seq
   import elink_pkg::*;
(
   input  logic sys_clk,
   input  logic reset_in,     // sync, active high
   input  logic link_en,
   input  logic pll_locked,   // async, from pll
   output logic pll_reset,
   output logic chip_resetb,  // active low
   output logic link_reset
);

   // ####################
   // heartbeat
   // ####################
   logic [`ELINK_TICK_W-1:0] tick_cnt;
   logic                     heartbeat;

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         tick_cnt  <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         tick_cnt  <= tick_cnt + 1'b1;    // free running, wraps
         heartbeat <= (tick_cnt == '0);   // one pulse per wrap
      end
   end

   // ####################
   // synchronizers
   // ####################
   logic [1:0] req_sync;    // reset request, two flops
   logic [1:0] lock_sync;   // pll lock, two flops
   logic       rst_req;
   logic       lock_s;

   always_ff @(posedge sys_clk)
   begin
      req_sync  <= {req_sync[0], reset_in | ~link_en};
      lock_sync <= {lock_sync[0], pll_locked};
   end

   assign rst_req = req_sync[1];
   assign lock_s  = lock_sync[1];

   // ####################
   // sequence fsm
   // ####################
   reset_state_t state;

   always_ff @(posedge sys_clk)
   begin
      if (reset_in || rst_req)
         state <= reset_all;
      else if (heartbeat)
      begin
         case (state)
            reset_all:  state <= start_pll;
            start_pll:  if (lock_s) state <= stop_pll;   // wait for first lock
            stop_pll:   state <= start_chip;
            start_chip: state <= hold;
            hold:       if (lock_s) state <= active;     // relock after quiet time
            active:     state <= active;                 // until next reset request
            default:    state <= reset_all;
         endcase
      end
   end

   // output decodes
   // pll held in reset around the chip reset edge
   assign pll_reset   = (state == reset_all) | (state == stop_pll) | (state == start_chip);
   assign chip_resetb = (state == start_chip) | (state == hold) | (state == active);
   assign link_reset  = (state != active);   // gates both tx stages

endmodule

// ==== verilog/elink_tx_framer.sv ====
/*
 * elink transmit framer
 * first tx stage, decodes control words and tags first and last word
 */
`include "elink_params.svh"

module elink_tx_framer
   import elink_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_in,
   input  logic       link_reset,
   input  link_word_u in_data,
   input  logic       in_valid,
   output logic       in_ready,
   output link_word_u word,
   output logic       word_first,
   output logic       word_last,
   output logic       word_valid,
   input  logic       word_ready
);

   localparam int unsigned LEN_W = `ELINK_LEN_W;

   logic [LEN_W-1:0] remain;        // data words still owed
   logic             expect_ctrl;   // next word is a header
   logic [LEN_W-1:0] hdr_len;
   logic             in_fire;
   logic             dec_first;
   logic             dec_last;

   // stall while link down or output held
   assign in_ready = ~link_reset & (~word_valid | word_ready);
   assign in_fire  = in_valid & in_ready;

   // length field through the header view
   assign hdr_len = in_data.hdr.len;

   // ####################
   // word decode
   // ####################
   always_comb
   begin
      if (expect_ctrl)
      begin
         dec_first = 1'b1;               // reserved opcodes pass as is
         dec_last  = (hdr_len == '0);    // header only
      end
      else
      begin
         dec_first = 1'b0;
         dec_last  = (remain == 1);      // final data word
      end
   end

   // control state emptied while link down
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || link_reset)
      begin
         word_valid  <= 1'b0;
         expect_ctrl <= 1'b1;
         remain      <= '0;
      end
      else
      begin
         if (in_fire)
            word_valid <= 1'b1;
         else if (word_ready)
            word_valid <= 1'b0;          // taken so stage empties
         if (in_fire)
         begin
            expect_ctrl <= dec_last;     // header after a last word
            remain      <= expect_ctrl ? hdr_len : remain - 1'b1;
         end
      end
   end

   // payload register
   always_ff @(posedge sys_clk)
   begin
      if (in_fire)
      begin
         word.raw   <= in_data.raw;
         word_first <= dec_first;
         word_last  <= dec_last;
      end
   end

endmodule

// ==== verilog/elink_tx_serializer.sv ====
/*
 * elink transmit serializer
 * second tx stage, sends each word as bytes msb first with a frame flag
 */
`include "elink_params.svh"

module elink_tx_serializer
   import elink_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_in,
   input  logic       link_reset,
   input  link_word_u word,
   input  logic       word_first,
   input  logic       word_last,
   input  logic       word_valid,
   output logic       word_ready,
   output logic [7:0] tx_data,
   output logic       tx_frame,
   output logic       tx_valid,
   input  logic       tx_ready
);

   localparam int unsigned      IDX_W    = $clog2(`ELINK_BYTES);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ELINK_BYTES - 1);

   logic [`ELINK_WORD_W-1:0] shift_reg;   // top byte on the wire
   logic [IDX_W-1:0]         byte_idx;
   logic                     cur_last;    // word in flight closes the frame
   logic                     frame_open;
   logic                     last_byte;
   logic                     load;
   logic                     tx_fire;

   assign last_byte = (byte_idx == LAST_IDX);
   assign tx_fire   = tx_valid & tx_ready;

   // reload on empty or on final byte, no bubble
   assign word_ready = ~link_reset & (~tx_valid | (tx_ready & last_byte));
   assign load       = word_valid & word_ready;

   assign tx_data  = shift_reg[`ELINK_WORD_W-1 -: 8];   // msb first
   assign tx_frame = frame_open;

   // ####################
   // byte control
   // ####################
   always_ff @(posedge sys_clk)
   begin
      if (reset_in || link_reset)
      begin
         tx_valid   <= 1'b0;
         byte_idx   <= '0;
         frame_open <= 1'b0;
      end
      else
      begin
         if (load)
         begin
            tx_valid <= 1'b1;            // valid the cycle after load
            byte_idx <= '0;
         end
         else if (tx_fire)
         begin
            tx_valid <= ~last_byte;      // drains unless reloaded
            byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
         end
         // a new first word wins over closing the old frame
         if (load && word_first)
            frame_open <= 1'b1;
         else if (tx_fire && last_byte && cur_last)
            frame_open <= 1'b0;
      end
   end

   // shift register, payload only
   always_ff @(posedge sys_clk)
   begin
      if (load)
      begin
         shift_reg <= word.raw;
         cur_last  <= word_last;
      end
      else if (tx_fire)
         shift_reg <= {shift_reg[`ELINK_WORD_W-9:0], 8'h00};   // next byte up
   end

endmodule

// ==== verilog/elink_tx_top.sv ====
/*
 * elink transmit top
 * reset sequencer gating a framer and serializer pipeline
 */
module elink_tx_top
   import elink_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_in,
   input  logic       link_en,
   input  logic       pll_locked,
   input  link_word_u in_data,
   input  logic       in_valid,
   output logic       in_ready,
   output logic [7:0] tx_data,
   output logic       tx_frame,
   output logic       tx_valid,
   input  logic       tx_ready,
   output logic       pll_reset,
   output logic       chip_resetb,
   output logic       link_reset
);

   // framer to serializer
   link_word_u word_bus;
   logic       word_first;
   logic       word_last;
   logic       word_valid;
   logic       word_ready;

   // ####################
   // bring-up
   // ####################
   elink_reset_seq i_reset_seq (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .link_en     (link_en),
      .pll_locked  (pll_locked),
      .pll_reset   (pll_reset),
      .chip_resetb (chip_resetb),
      .link_reset  (link_reset)    // only signal into the stages
   );

   // ####################
   // tx pipeline
   // ####################
   elink_tx_framer i_framer (
      .sys_clk    (sys_clk),
      .reset_in   (reset_in),
      .link_reset (link_reset),
      .in_data    (in_data),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .word       (word_bus),
      .word_first (word_first),
      .word_last  (word_last),
      .word_valid (word_valid),
      .word_ready (word_ready)
   );

   elink_tx_serializer i_serializer (
      .sys_clk    (sys_clk),
      .reset_in   (reset_in),
      .link_reset (link_reset),
      .word       (word_bus),
      .word_first (word_first),
      .word_last  (word_last),
      .word_valid (word_valid),
      .word_ready (word_ready),
      .tx_data    (tx_data),
      .tx_frame   (tx_frame),
      .tx_valid   (tx_valid),
      .tx_ready   (tx_ready)
   );

endmodule

// ==== verif/elink_clk_gen.sv ====
/*
 * elink testbench clock
 * free running sys_clk, starts low
 */
module elink_clk_gen #(
   parameter int unsigned PERIOD = 8   // time units per cycle
)(
   output logic sys_clk
);

   initial
   begin
      sys_clk = 1'b0;
      forever
         #(PERIOD / 2) sys_clk = ~sys_clk;   // half period per phase
   end

endmodule

// ==== verif/elink_sva.sv ====
/*
 * elink transmit assertions
 * reset ordering, byte stream hold rule and input gating, bound to the top
 */
module elink_sva
   import elink_pkg::*;
(
   input logic         sys_clk,
   input logic         reset_in,
   input logic         pll_reset,
   input logic         chip_resetb,
   input logic         link_reset,
   input logic         in_ready,
   input logic [7:0]   tx_data,
   input logic         tx_valid,
   input logic         tx_ready,
   input reset_state_t seq_state     // sequencer state, from inside the top
);

   int unsigned fail_count = 0;      // polled by the testbench

   // ####################
   // reset order
   // ####################
   chip_after_pll: assert property (@(posedge sys_clk) disable iff (reset_in)
      (chip_resetb && pll_reset) |-> (seq_state == start_chip))
   else
   begin
      fail_count++;
      $error("chip_resetb high with pll_reset outside start_chip");
   end

   // ####################
   // byte stream
   // ####################
   tx_hold: assert property (@(posedge sys_clk) disable iff (reset_in || link_reset)
      (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
   else
   begin
      fail_count++;
      $error("tx byte dropped or changed before tx_ready");
   end

   gate_input: assert property (@(posedge sys_clk) disable iff (reset_in)
      link_reset |-> !in_ready)      // no words while link is down
   else
   begin
      fail_count++;
      $error("in_ready high while link_reset is high");
   end

endmodule

bind elink_tx_top elink_sva i_sva (
   .sys_clk     (sys_clk),
   .reset_in    (reset_in),
   .pll_reset   (pll_reset),
   .chip_resetb (chip_resetb),
   .link_reset  (link_reset),
   .in_ready    (in_ready),
   .tx_data     (tx_data),
   .tx_valid    (tx_valid),
   .tx_ready    (tx_ready),
   .seq_state   (i_reset_seq.state)
);

// ==== verif/elink_tb.sv ====
/*
 * elink transmit testbench
 * pll lock model, word source, byte sink with random back-pressure,
 * reference byte stream and a compare process on every byte transfer
 */
`include "elink_params.svh"

module elink_tb
   import elink_pkg::*;
();

   logic       sys_clk;
   logic       reset_in;
   logic       link_en;
   logic       pll_locked;
   link_word_u in_data;
   logic       in_valid;
   logic       in_ready;
   logic [7:0] tx_data;
   logic       tx_frame;
   logic       tx_valid;
   logic       tx_ready;
   logic       pll_reset;
   logic       chip_resetb;
   logic       link_reset;

   int          seed       = 32'h404ac117;                 // words and gaps
   int          ready_seed = 32'h404ac117 ^ 32'h0000_ffff; // own stream, tx_ready
   int          pll_seed   = 32'h404ac117 ^ 32'hffff_0000; // own stream, lock delay
   logic [31:0] sent_words[$];   // all words in send order
   logic [9:0]  exp_q[$];        // {ends transaction, frame, byte}
   logic [9:0]  exp_entry;
   bit          frame_open;      // expected frame state after last byte
   bit          stress;          // random gaps and tx_ready
   bit          stim_ready;
   int          lock_delay;
   int          split_a;
   int          split_b;
   longint      wd_cycles;

   elink_clk_gen #(.PERIOD(8)) i_clk_gen (.sys_clk(sys_clk));

   elink_tx_top i_elink_tx_top (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .link_en     (link_en),
      .pll_locked  (pll_locked),
      .in_data     (in_data),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .tx_data     (tx_data),
      .tx_frame    (tx_frame),
      .tx_valid    (tx_valid),
      .tx_ready    (tx_ready),
      .pll_reset   (pll_reset),
      .chip_resetb (chip_resetb),
      .link_reset  (link_reset)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         abort_run("stopping at first error");
      end
   endtask

   // random transactions, header = opcode, length, address
   function automatic void build_batch(input int n_txn);
      logic [3:0]  op;
      logic [3:0]  len;
      logic [23:0] addr;
      int          t;
      int          k;
      for (t = 0; t < n_txn; t++)
      begin
         case ({$random(seed)} % 5)
            0:       op = write;
            1:       op = read;
            2:       op = read_response;
            default: op = 4'($random(seed));   // mostly reserved codes
         endcase
         len  = 4'({$random(seed)} % (`ELINK_MAX_LEN + 1));
         addr = 24'($random(seed));
         sent_words.push_back({op, len, addr});
         for (k = 0; k < len; k++)
            sent_words.push_back($random(seed));
      end
   endfunction

   // reference: four bytes per word msb first, every transaction byte framed
   function automatic void predict_bytes();
      logic [31:0] w;
      int          remain;
      bit          want_ctrl;
      bit          last;
      int          i;
      int          b;
      want_ctrl = 1'b1;
      remain    = 0;
      for (i = 0; i < sent_words.size(); i++)
      begin
         w = sent_words[i];
         if (want_ctrl)
            remain = w[27:24];            // length field of the header
         else
            remain = remain - 1;
         last      = (remain == 0);
         want_ctrl = last;
         for (b = 0; b < 4; b++)
            exp_q.push_back({last && (b == 3), 1'b1, w[31 - 8*b -: 8]});
      end
   endfunction

   task automatic send_words(input int from, input int to);
      int i;
      int gap;
      for (i = from; i < to; i++)
      begin
         gap = stress ? {$random(seed)} % 4 : 0;
         repeat (gap) @(negedge sys_clk);
         in_data.raw = sent_words[i];
         in_valid    = 1'b1;
         @(posedge sys_clk);
         while (!in_ready)
            @(posedge sys_clk);          // held until taken
         @(negedge sys_clk);
         in_valid = 1'b0;
      end
   endtask

   task automatic wait_drained(input int upto);
      int n;
      n = 0;
      while (exp_q.size() > 4 * (sent_words.size() - upto))
      begin
         @(posedge sys_clk);
         n++;
         if (n > 64 * sent_words.size() + 200)
            abort_run("byte stream stopped before all words came out");
      end
   endtask

   // bring-up order, lock and chip reset release seen before link is up
   task automatic wait_link_up();
      int n;
      bit saw_lock;
      bit saw_chip;
      n        = 0;
      saw_lock = 1'b0;
      saw_chip = 1'b0;
      @(posedge sys_clk);
      while (link_reset !== 1'b0)
      begin
         saw_lock = saw_lock | (pll_locked === 1'b1);
         saw_chip = saw_chip | (chip_resetb === 1'b1);
         n++;
         if (n > 2000)
            abort_run("link_reset never fell, link did not come up");
         @(posedge sys_clk);
      end
      check_value(saw_chip, 1, "chip_resetb high before link_reset fell");
      check_value(saw_lock, 1, "pll_locked high before link_reset fell");
   endtask

   // ####################
   // pll lock model
   // ####################
   initial
   begin
      pll_locked = 1'b0;
      lock_delay = 0;
      forever
      begin
         @(negedge sys_clk);
         if (pll_reset !== 1'b0)
         begin
            pll_locked = 1'b0;           // lost while in reset
            lock_delay = 20 + {$random(pll_seed)} % 41;
         end
         else if (lock_delay > 0)
            lock_delay--;
         else
            pll_locked = 1'b1;
      end
   end

   // sink readiness, random only under stress
   initial
   begin
      tx_ready = 1'b1;
      forever
      begin
         @(negedge sys_clk);
         tx_ready = stress ? ({$random(ready_seed)} % 3 != 0) : 1'b1;
      end
   end

   // ####################
   // compare
   // ####################
   always @(posedge sys_clk)
   begin
      if (tx_valid === 1'b1 && tx_ready === 1'b1)
      begin
         if (exp_q.size() == 0)
            abort_run("byte sent with no word outstanding");
         else
         begin
            exp_entry = exp_q.pop_front();
            check_value(tx_data, exp_entry[7:0], "tx_data");
            check_value(tx_frame, exp_entry[8], "tx_frame");
            frame_open = ~exp_entry[9];
         end
      end
      else if (!reset_in && tx_valid === 1'b0 && !frame_open)
         check_value(tx_frame, 0, "tx_frame between transactions");
      if (i_elink_tx_top.i_sva.fail_count != 0)
         abort_run("an assertion in elink_sva failed");
   end

   initial
   begin
      wait (stim_ready);
      wd_cycles = longint'(sent_words.size()) * 4 * 8 + 2000;
      #(wd_cycles * 8);
      abort_run("watchdog expired before the tests finished");
   end

   // ####################
   // main sequence
   // ####################
   initial
   begin
      reset_in    = 1'b1;
      link_en     = 1'b1;
      in_valid    = 1'b0;
      in_data.raw = '0;
      stress      = 1'b0;
      frame_open  = 1'b0;
      build_batch(5);
      split_a = sent_words.size();
      build_batch(8);
      split_b = sent_words.size();
      build_batch(6);
      predict_bytes();
      stim_ready = 1'b1;
      repeat (16) @(negedge sys_clk);
      reset_in = 1'b0;
      @(posedge sys_clk);
      check_value(link_reset, 1, "link_reset after reset");
      check_value(chip_resetb, 0, "chip_resetb after reset");
      check_value(pll_reset, 1, "pll_reset after reset");
      wait_link_up();
      @(negedge sys_clk);
      send_words(0, split_a);               // plain streaming
      wait_drained(split_a);
      stress = 1'b1;                        // gaps and back-pressure
      @(negedge sys_clk);
      send_words(split_a, split_b);
      wait_drained(split_b);
      @(negedge sys_clk);
      link_en = 1'b0;                       // link drop
      repeat (4) @(posedge sys_clk);        // two sync flops, then state
      check_value(link_reset, 1, "link_reset after link_en fell");
      repeat (50)
      begin
         @(posedge sys_clk);
         check_value(in_ready, 0, "in_ready while link down");
         check_value(tx_valid, 0, "tx_valid while link down");
      end
      @(negedge sys_clk);
      link_en = 1'b1;
      wait_link_up();
      @(negedge sys_clk);
      send_words(split_b, sent_words.size());
      wait_drained(sent_words.size());
      repeat (10) @(posedge sys_clk);
      if (i_elink_tx_top.i_sva.fail_count != 0)
         abort_run("an assertion in elink_sva failed");
      else
      begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
+incdir+include
verilog/elink_pkg.sv
verilog/elink_reset_seq.sv
verilog/elink_tx_framer.sv
verilog/elink_tx_serializer.sv
verilog/elink_tx_top.sv
verif/elink_clk_gen.sv
verif/elink_sva.sv
verif/elink_tb.sv

// ==== Bender.yml ====
package:
  name: elink_tx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/elink_pkg.sv
      - verilog/elink_reset_seq.sv
      - verilog/elink_tx_framer.sv
      - verilog/elink_tx_serializer.sv
      - verilog/elink_tx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/elink_clk_gen.sv
      - verif/elink_sva.sv
      - verif/elink_tb.sv
